//--- flist.f
verilog/mipsPkg.sv
verilog/mainDecoder.sv
verilog/cycleFsm.sv
verilog/pcUnit.sv
verilog/regFile.sv
verilog/alu.sv
verilog/mipsCore.sv
test/mipsCore_assert.sv
test/tbMipsCore.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - verilog/mipsPkg.sv
  - verilog/mainDecoder.sv
  - verilog/cycleFsm.sv
  - verilog/pcUnit.sv
  - verilog/regFile.sv
  - verilog/alu.sv
  - verilog/mipsCore.sv
  - target: test
    files:
      - test/mipsCore_assert.sv
      - test/tbMipsCore.sv

//--- test/tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;

    localparam logic [31:0] RESET = 32'h100;
    localparam int TOTAL_INSTR = 61;                    // all program words, illegal halt included
    localparam int MAX_CYCLES = 5 * TOTAL_INSTR + 200;

    logic        clk, rstN, memWrite, memRead, halted;
    logic [31:0] instrAddr, instr, memAddr, memWdata, memRdata, lfsr;
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] wrLog [$];
    logic [31:0] rdLog [$];
    logic [31:0] pcLog [$];                             // distinct instrAddr values
    int          cycles = 0;

    mipsCore #(.RESET_ADDR(RESET)) UUT (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .memAddr(memAddr),
        .memWdata(memWdata), .memWrite(memWrite), .memRead(memRead), .memRdata(memRdata),
        .halted(halted)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // memory models and logs
    ////////////////////////////////////////////////////////////

    assign instr    = imem[instrAddr[7:2]];             // combinational fetch
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[memAddr[7:2]] <= memWdata;
            wrLog.push_back(memAddr);
        end
        if (memRead)
            rdLog.push_back(memAddr);
        if (rstN && (pcLog.size() == 0 || pcLog[$] != instrAddr))
            pcLog.push_back(instrAddr);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stopRun();
        end else if (UUT.uAssert.failCount != 0) begin
            $display("a concurrent assertion on the core failed");
            stopRun();
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    function logic [31:0] randomWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsrNext(lfsr);                      // one step per bit
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs, rt, rd,
                                          input logic [4:0] shamt);
        return {6'h0, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic stopRun();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            stopRun();
        end
    endtask

    task automatic expectLog(input string what, input logic [31:0] got[$],
                             input logic [31:0] exp[$]);
        expectEq(got.size(), exp.size(), {what, " length"});
        foreach (exp[i])
            expectEq(got[i], exp[i], $sformatf("%s entry %0d", what, i));
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {6'h3f, 18'h0, i[5:0], 2'b00};   // illegal opcode everywhere
            dmem[i] = 32'hd0d0_0000 | (i << 2);
        end
    endtask

    task automatic runProgram();
        @(negedge clk);
        rstN = 1'b0;
        repeat (5) @(negedge clk);
        expectEq(instrAddr, RESET, "instrAddr in reset");
        expectEq({memWrite, memRead, halted}, 3'b000, "strobes and halted in reset");
        wrLog.delete();
        rdLog.delete();
        pcLog.delete();
        rstN = 1'b1;
        while (!halted)
            @(negedge clk);                             // watchdog bounds this wait
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic registerOps();
        logic [31:0] a, b, exp;
        logic [5:0]  fn [7];
        a = randomWord();
        b = randomWord();
        fn = '{mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND, mipsPkg::FN_OR,
               mipsPkg::FN_XOR, mipsPkg::FN_NOR, mipsPkg::FN_SLT};
        clearMemories();
        dmem[0] = a;
        dmem[1] = b;
        imem[0] = iType(mipsPkg::OP_LW, 0, 1, 16'h0);
        imem[1] = iType(mipsPkg::OP_LW, 0, 2, 16'h4);
        for (int k = 0; k < 7; k++) begin
            imem[2 + 2 * k] = rType(fn[k], 1, 2, 3, 0);
            imem[3 + 2 * k] = iType(mipsPkg::OP_SW, 0, 3, 16'h40 + 4 * k);
        end
        imem[16] = rType(mipsPkg::FN_ADD, 1, 2, 0, 0);  // r0 target
        imem[17] = iType(mipsPkg::OP_SW, 0, 0, 16'h5c);
        imem[18] = rType(6'h3f, 0, 0, 0, 0);            // unknown funct halts
        runProgram();
        for (int k = 0; k < 7; k++) begin
            case (k)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a & b;
                3: exp = a | b;
                4: exp = a ^ b;
                5: exp = ~(a | b);
                default: exp = {31'h0, $signed(a) < $signed(b)};
            endcase
            expectEq(dmem[16 + k], exp, $sformatf("R-type result %0d", k));
        end
        expectEq(dmem[23], 32'h0, "store of r0");
    endtask

    task automatic shiftAndImmediate();
        logic [31:0] a;
        logic [31:0] ops [7];
        logic [31:0] exp [7];
        a = randomWord();
        clearMemories();
        dmem[0] = a;
        ops = '{rType(mipsPkg::FN_SLL, 0, 1, 2, 5), rType(mipsPkg::FN_SRL, 0, 1, 2, 7),
                iType(mipsPkg::OP_ANDI, 1, 2, 16'h8f0f), iType(mipsPkg::OP_ORI, 1, 2, 16'h8001),
                iType(mipsPkg::OP_XORI, 1, 2, 16'hf0f0), iType(mipsPkg::OP_SLTI, 1, 2, 16'h8000),
                iType(mipsPkg::OP_SLTI, 1, 2, 16'h7fff)};
        exp = '{a << 5, a >> 7, a & 32'h0000_8f0f, a | 32'h0000_8001, a ^ 32'h0000_f0f0,
                {31'h0, $signed(a) < $signed(32'hffff_8000)},
                {31'h0, $signed(a) < $signed(32'h0000_7fff)}};
        imem[0] = iType(mipsPkg::OP_LW, 0, 1, 16'h0);
        for (int k = 0; k < 7; k++) begin
            imem[1 + 2 * k] = ops[k];
            imem[2 + 2 * k] = iType(mipsPkg::OP_SW, 0, 2, 16'h40 + 4 * k);
        end
        runProgram();
        for (int k = 0; k < 7; k++)
            expectEq(dmem[16 + k], exp[k], $sformatf("shift or immediate result %0d", k));
    endtask

    task automatic copyWithOffsets();
        logic [31:0] v1, v2;
        v1 = randomWord();
        v2 = randomWord();
        clearMemories();
        dmem[0]  = 32'h80;                              // base address
        dmem[34] = v1;
        dmem[31] = v2;
        imem[0] = iType(mipsPkg::OP_LW, 0, 1, 16'h0);
        imem[1] = iType(mipsPkg::OP_LW, 1, 2, 16'h8);
        imem[2] = iType(mipsPkg::OP_SW, 1, 2, 16'hfff0); // negative offset
        imem[3] = iType(mipsPkg::OP_LW, 1, 3, 16'hfffc);
        imem[4] = iType(mipsPkg::OP_SW, 1, 3, 16'h20);
        runProgram();
        expectEq(dmem[28], v1, "word copied to 0x70");
        expectEq(dmem[40], v2, "word copied to 0xa0");
        expectLog("read addresses", rdLog, '{32'h0, 32'h88, 32'h7c});
        expectLog("write addresses", wrLog, '{32'h70, 32'ha0});
    endtask

    task automatic branchAndJump();
        logic [31:0] v;
        v = randomWord();
        clearMemories();
        dmem[0] = v;
        imem[0]  = iType(mipsPkg::OP_LW, 0, 1, 16'h0);
        imem[1]  = iType(mipsPkg::OP_LW, 0, 2, 16'h0);
        imem[2]  = iType(mipsPkg::OP_BEQ, 1, 2, 16'h2); // equal, skips two words
        imem[3]  = iType(mipsPkg::OP_SW, 0, 1, 16'h40);
        imem[4]  = iType(mipsPkg::OP_SW, 0, 1, 16'h40);
        imem[5]  = iType(mipsPkg::OP_BNE, 1, 2, 16'h2); // equal, falls through
        imem[6]  = iType(mipsPkg::OP_SW, 0, 1, 16'h44);
        imem[7]  = {mipsPkg::OP_J, 26'((RESET + 32'h28) >> 2)};
        imem[8]  = iType(mipsPkg::OP_SW, 0, 1, 16'h48);
        imem[9]  = iType(mipsPkg::OP_SW, 0, 1, 16'h48);
        imem[10] = iType(mipsPkg::OP_SW, 0, 2, 16'h4c);
        runProgram();
        expectLog("write addresses", wrLog, '{32'h44, 32'h4c});
        expectEq(dmem[17], v, "store after bne");
        expectEq(dmem[19], v, "store after j");
        expectLog("instrAddr sequence", pcLog, '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h114,
                                                 32'h118, 32'h11c, 32'h120, 32'h128, 32'h12c,
                                                 32'h130});
    endtask

    task automatic illegalHalts();
        logic [31:0] v, stopAddr;
        v = randomWord();
        clearMemories();
        dmem[0] = v;
        imem[0] = iType(mipsPkg::OP_LW, 0, 1, 16'h0);
        imem[1] = iType(mipsPkg::OP_SW, 0, 1, 16'h40);
        imem[2] = iType(6'b001000, 1, 1, 16'h1);        // addi is not kept
        imem[3] = iType(mipsPkg::OP_SW, 0, 1, 16'h44);
        runProgram();
        stopAddr = instrAddr;
        repeat (10) @(negedge clk);                     // watch the halted core
        expectEq(halted, 1'b1, "halted");
        expectEq(instrAddr, stopAddr, "instrAddr while halted");
        expectEq(stopAddr, RESET + 32'hc, "instrAddr after illegal fetch");
        expectLog("write addresses", wrLog, '{32'h40});
        expectEq(dmem[16], v, "store before the illegal word");
        runProgram();                                   // reset leaves HALT
        expectEq(pcLog[0], RESET, "first fetch after reset");
        expectLog("write addresses after reset", wrLog, '{32'h40});
    endtask

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        lfsr = 32'h850a_eed5;
        registerOps();
        shiftAndImmediate();
        copyWithOffsets();
        branchAndJump();
        illegalHalts();
        if (UUT.uAssert.failCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("concurrent assertions on the core failed");
            stopRun();
        end
    end

endmodule

//--- test/mipsCore_assert.sv
`timescale 1ns/1ps

module mipsCoreAssert (
    input logic           clk,
    input logic           rstN,
    input logic           memRead,
    input logic           memWrite,
    input logic           halted,
    input mipsPkg::stateE state
);

    int failCount = 0;                                  // read by the testbench

    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite))
        else begin $error("memRead and memWrite high together"); failCount++; end

    readOneCycle: assert property (@(posedge clk) disable iff (!rstN) memRead |=> !memRead)
        else begin $error("memRead held longer than one cycle"); failCount++; end

    writeOneCycle: assert property (@(posedge clk) disable iff (!rstN) memWrite |=> !memWrite)
        else begin $error("memWrite held longer than one cycle"); failCount++; end

    // only reset leaves HALT
    haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else begin $error("halted fell without reset"); failCount++; end

    // MEMORY is entered for loads and stores only
    memoryHasStrobe: assert property (@(posedge clk) disable iff (!rstN)
        (state == mipsPkg::MEMORY) |-> (memRead || memWrite))
        else begin $error("MEMORY phase without a memory strobe"); failCount++; end

endmodule

bind mipsCore mipsCoreAssert uAssert (
    .clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite), .halted(halted),
    .state(state)
);

//--- verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
    parameter logic [31:0] RESET_ADDR = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata,
    output logic        memWrite,
    output logic        memRead,
    input  logic [31:0] memRdata,
    output logic        halted
);

    mipsPkg::instrT instrReg;
    mipsPkg::ctrlT  ctrl;
    mipsPkg::stateE state;
    logic           illegal, irLoad, decodeEn, execEn, memEn, wbEn, pcLoad;
    logic [31:0]    rsData, rtData, immExt, aluB, aluY, wData;
    logic [31:0]    rsQ, rtQ, immQ, aluQ, mdrQ;
    logic           aluZero;
    logic [4:0]     wAddr;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    mainDecoder uDecoder (.instr(instrReg), .ctrl(ctrl), .illegal(illegal));

    cycleFsm uFsm (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .illegal(illegal),
        .irLoad(irLoad), .decodeEn(decodeEn), .execEn(execEn), .memEn(memEn),
        .wbEn(wbEn), .pcLoad(pcLoad), .halted(halted), .state(state)
    );

    // branch decision uses zero from the latched operands
    pcUnit #(.RESET_ADDR(RESET_ADDR)) uPc (
        .clk(clk), .rstN(rstN), .step(irLoad), .pcLoad(pcLoad), .ctrl(ctrl),
        .zero(aluZero), .instr(instrReg), .pc(instrAddr)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    assign immExt = ctrl.zeroExt ? {16'h0, instrReg.iFields.imm16}
                                 : {{16{instrReg.iFields.imm16[15]}}, instrReg.iFields.imm16};
    assign aluB   = ctrl.aluSrc ? immQ : rtQ;
    assign wAddr  = ctrl.regDst ? instrReg.rFields.rd : instrReg.rFields.rt;
    assign wData  = ctrl.memToReg ? mdrQ : aluQ;

    regFile uRegs (
        .clk(clk), .wbEn(wbEn), .rs(instrReg.rFields.rs), .rt(instrReg.rFields.rt),
        .wAddr(wAddr), .wData(wData), .rsData(rsData), .rtData(rtData)
    );

    alu uAlu (
        .op(ctrl.aluOp), .a(rsQ), .b(aluB), .shamt(instrReg.rFields.shamt),
        .y(aluY), .zero(aluZero)
    );

    always_ff @(posedge clk) begin
        if (irLoad)
            instrReg <= instr;
        if (decodeEn) begin                 // operands and immediate
            rsQ  <= rsData;
            rtQ  <= rtData;
            immQ <= immExt;
        end
        if (execEn)
            aluQ <= aluY;
        if (memEn)
            mdrQ <= memRdata;               // load data, same-cycle answer
    end

    // data side, strobes only in MEMORY
    assign memAddr  = aluQ;
    assign memWdata = rtQ;
    assign memRead  = memEn & ctrl.memRead;
    assign memWrite = memEn & ctrl.memWrite;

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  mipsPkg::aluOpE op,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  logic [4:0]     shamt,
    output logic [31:0]    y,
    output logic           zero
);

    logic lessThan;

    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            mipsPkg::ALU_ADD: y = a + b;
            mipsPkg::ALU_SUB: y = a - b;            // also the branch compare
            mipsPkg::ALU_AND: y = a & b;
            mipsPkg::ALU_OR:  y = a | b;
            mipsPkg::ALU_XOR: y = a ^ b;
            mipsPkg::ALU_NOR: y = ~(a | b);
            mipsPkg::ALU_SLT: y = {31'h0, lessThan};
            mipsPkg::ALU_SLL: y = b << shamt;       // shifts act on rt
            mipsPkg::ALU_SRL: y = b >> shamt;
            default:          y = 32'h0;
        endcase
    end

    assign zero = (y == 32'h0);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        wbEn,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wbEn && (wAddr != 5'd0))
            regs[wAddr] <= wData;           // r0 never written
    end

    // r0 is hardwired to zero
    assign rsData = (rs == 5'd0) ? 32'h0 : regs[rs];
    assign rtData = (rt == 5'd0) ? 32'h0 : regs[rt];

endmodule

//--- verilog/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
    parameter logic [31:0] RESET_ADDR = 32'h0
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           step,
    input  logic           pcLoad,
    input  mipsPkg::ctrlT  ctrl,
    input  logic           zero,
    input  mipsPkg::instrT instr,
    output logic [31:0]    pc
);

    logic        taken;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;

    // pc already points at the next instruction here
    assign taken        = ctrl.jump | (ctrl.branch & zero) | (ctrl.branchNe & ~zero);
    assign branchTarget = pc + {{14{instr.iFields.imm16[15]}}, instr.iFields.imm16, 2'b00};
    assign jumpTarget   = {pc[31:28], instr.jFields.target26, 2'b00};

    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= RESET_ADDR;
        else if (step)
            pc <= pc + 32'd4;               // fetch phase
        else if (pcLoad && taken)
            pc <= ctrl.jump ? jumpTarget : branchTarget;
    end

endmodule

//--- verilog/cycleFsm.sv
`timescale 1ns/1ps

module cycleFsm (
    input  logic           clk,
    input  logic           rstN,
    input  mipsPkg::ctrlT  ctrl,
    input  logic           illegal,
    output logic           irLoad,
    output logic           decodeEn,
    output logic           execEn,
    output logic           memEn,
    output logic           wbEn,
    output logic           pcLoad,
    output logic           halted,
    output mipsPkg::stateE state
);

    mipsPkg::stateE nextState;
    logic           isFlow;                 // branch or jump, ends in EXECUTE

    assign isFlow = ctrl.branch | ctrl.branchNe | ctrl.jump;

    always_comb begin
        nextState = state;
        case (state)
            mipsPkg::FETCH:     nextState = mipsPkg::DECODE;
            mipsPkg::DECODE:    nextState = illegal ? mipsPkg::HALT : mipsPkg::EXECUTE;
            mipsPkg::EXECUTE: begin
                if (isFlow)
                    nextState = mipsPkg::FETCH;
                else if (ctrl.memRead || ctrl.memWrite)
                    nextState = mipsPkg::MEMORY;
                else if (ctrl.regWrite)
                    nextState = mipsPkg::WRITEBACK;
                else
                    nextState = mipsPkg::FETCH;
            end
            mipsPkg::MEMORY:    nextState = ctrl.regWrite ? mipsPkg::WRITEBACK : mipsPkg::FETCH;
            mipsPkg::WRITEBACK: nextState = mipsPkg::FETCH;
            default:            nextState = mipsPkg::HALT;  // only reset leaves HALT
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            state <= mipsPkg::FETCH;
        else
            state <= nextState;
    end

    // one enable per phase
    assign irLoad   = (state == mipsPkg::FETCH);
    assign decodeEn = (state == mipsPkg::DECODE);
    assign execEn   = (state == mipsPkg::EXECUTE);
    assign memEn    = (state == mipsPkg::MEMORY);
    assign wbEn     = (state == mipsPkg::WRITEBACK);
    assign pcLoad   = execEn & isFlow;
    assign halted   = (state == mipsPkg::HALT);

endmodule

//--- verilog/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder (
    input  mipsPkg::instrT instr,
    output mipsPkg::ctrlT  ctrl,
    output logic           illegal
);

    always_comb begin
        ctrl    = '0;                       // don't-cares come out as zero
        illegal = 1'b0;
        case (instr.rFields.opcode)
            mipsPkg::OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (instr.rFields.funct)  // funct picks the ALU operation
                    mipsPkg::FN_ADD: ctrl.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: ctrl.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  ctrl.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR: ctrl.aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::FN_NOR: ctrl.aluOp = mipsPkg::ALU_NOR;
                    mipsPkg::FN_SLT: ctrl.aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLL: ctrl.aluOp = mipsPkg::ALU_SLL;
                    mipsPkg::FN_SRL: ctrl.aluOp = mipsPkg::ALU_SRL;
                    default: begin
                        ctrl    = '0;       // unknown funct, no writes
                        illegal = 1'b1;
                    end
                endcase
            end
            mipsPkg::OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_ADD;   // base plus offset
            end
            mipsPkg::OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_ADD;
            end
            mipsPkg::OP_ANDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_AND;
            end
            mipsPkg::OP_ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_OR;
            end
            mipsPkg::OP_XORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_XOR;
            end
            mipsPkg::OP_SLTI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_SLT;   // signed compare
            end
            mipsPkg::OP_BEQ: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_SUB;   // zero on equal
            end
            mipsPkg::OP_BNE: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_SUB;
            end
            mipsPkg::OP_J: begin
                ctrl.jump     = 1'b1;
            end
            default: begin
                illegal = 1'b1;             // anything else traps
            end
        endcase
    end

endmodule

//--- verilog/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL = 6'b000000,
        FN_SRL = 6'b000010,
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_XOR = 6'b100110,
        FN_NOR = 6'b100111,
        FN_SLT = 6'b101010
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL
    } aluOpE;

    ////////////////////////////////////////////////////////////
    // decoder outputs and instruction views
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   regWrite;
        logic   aluSrc;     // 1 selects the extended immediate
        logic   regDst;     // 1 writes rd, 0 writes rt
        logic   memWrite;
        logic   memRead;
        logic   memToReg;   // 1 writes back load data
        logic   branch;     // beq
        logic   branchNe;   // bne
        logic   jump;
        logic   zeroExt;    // logical immediates
        aluOpE  aluOp;
    } ctrlT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFieldsT;

    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
        jFieldsT jFields;
    } instrT;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
    } stateE;

endpackage
